//--- vga_macros.svh
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// 800x600 at 60 Hz, 40 MHz pixel clock, both syncs active high

`define HOR_PIXELS      800
`define HOR_TOTAL       1056
`define HOR_SYNC_START  840
`define HOR_SYNC_END    967         // inclusive

`define VER_PIXELS      600
`define VER_TOTAL       628
`define VER_SYNC_START  601
`define VER_SYNC_END    604         // inclusive

// moving rectangle size
`define RECT_WIDTH      48
`define RECT_HEIGHT     64

// filled circle, radius squared avoids a sqrt
`define CIRCLE_X        400
`define CIRCLE_Y        300
`define CIRCLE_R2       40000

// letter block origin and stroke width
`define LETTER_X0       (`HOR_PIXELS / 3)
`define LETTER_Y0       (`VER_PIXELS / 3)
`define STROKE          20

// 12-bit colours, rrrr_gggg_bbbb
`define COLOR_TOP       12'hffa     // yellow
`define COLOR_BOTTOM    12'hf00     // red
`define COLOR_LEFT      12'h0f0     // green
`define COLOR_RIGHT     12'h00f     // blue
`define COLOR_LETTER    12'ha0a     // magenta
`define COLOR_CIRCLE    12'hfd8
`define COLOR_FILL      12'haaa     // gray
`define COLOR_RECT      12'h0cc

`endif

//--- vga_pkg.sv
`default_nettype none

package vga_pkg;

    // pixel counter, horizontal and vertical
    typedef logic [10:0] count_t;

    // 4 bits each of red, green, blue from the top
    typedef logic [11:0] rgb_t;

    // top-left corner of the rectangle
    typedef struct packed {
        count_t x;
        count_t y;
    } pos_t;

    // one pixel beat as it travels down the pipeline
    typedef struct packed {
        count_t vcount;
        logic   vsync;
        logic   vblnk;
        count_t hcount;
        logic   hsync;
        logic   hblnk;
        rgb_t   rgb;
    } vga_sig_t;

endpackage

`default_nettype wire

//--- vga_timing.sv
`timescale 1ns/10ps
`default_nettype none

`include "vga_macros.svh"

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_sig_t tim_sig
);

    import vga_pkg::*;

    count_t   hcount_nxt;
    count_t   vcount_nxt;
    vga_sig_t tim_nxt;

    // counter next state, the registered struct holds the current count
    always_comb begin
        if (tim_sig.hcount == count_t'(`HOR_TOTAL - 1)) begin
            hcount_nxt = '0;                                    // end of line
            if (tim_sig.vcount == count_t'(`VER_TOTAL - 1)) begin
                vcount_nxt = '0;                                // end of frame
            end else begin
                vcount_nxt = tim_sig.vcount + 11'd1;
            end
        end else begin
            hcount_nxt = tim_sig.hcount + 11'd1;
            vcount_nxt = tim_sig.vcount;
        end
    end

    // sync and blank decoded from the next count so they line up
    // with the counter values once registered
    always_comb begin
        tim_nxt.hcount = hcount_nxt;
        tim_nxt.vcount = vcount_nxt;
        tim_nxt.hblnk  = (hcount_nxt >= count_t'(`HOR_PIXELS));
        tim_nxt.vblnk  = (vcount_nxt >= count_t'(`VER_PIXELS));
        tim_nxt.hsync  = (hcount_nxt >= count_t'(`HOR_SYNC_START)) &&
                         (hcount_nxt <= count_t'(`HOR_SYNC_END));    // active high
        tim_nxt.vsync  = (vcount_nxt >= count_t'(`VER_SYNC_START)) &&
                         (vcount_nxt <= count_t'(`VER_SYNC_END));    // active high
        tim_nxt.rgb    = '0;                                // colour added downstream
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tim_sig <= '0;                                  // counts restart at 0,0
        end else begin
            tim_sig <= tim_nxt;
        end
    end

endmodule

`default_nettype wire

//--- draw_bg.sv
`timescale 1ns/10ps
`default_nettype none

`include "vga_macros.svh"

module draw_bg (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_sig_t bg_in,
    output vga_pkg::vga_sig_t bg_out
);

    import vga_pkg::*;

    vga_sig_t           bg_nxt;
    rgb_t               rgb_nxt;
    logic               letter_1;
    logic               letter_2;
    logic               in_circle;
    logic signed [12:0] dx;
    logic signed [12:0] dy;
    logic signed [25:0] dist2;

    // inclusive box given relative to the letter origin
    function automatic logic in_box(input count_t h, input count_t v,
                                    input int x_lo, input int x_hi,
                                    input int y_lo, input int y_hi);
        return (h >= `LETTER_X0 + x_lo) && (h <= `LETTER_X0 + x_hi) &&
               (v >= `LETTER_Y0 + y_lo) && (v <= `LETTER_Y0 + y_hi);
    endfunction

    // first letter, open at the bottom with a short middle bar
    assign letter_1 = in_box(bg_in.hcount, bg_in.vcount, 0, `STROKE, 0, 200) ||
                      in_box(bg_in.hcount, bg_in.vcount, 0, 120, 0, `STROKE) ||
                      in_box(bg_in.hcount, bg_in.vcount, 120, 140, 0, 200) ||
                      in_box(bg_in.hcount, bg_in.vcount, 60, 80, 0, 120);

    // second letter, mirrored shape closed at the bottom
    assign letter_2 = in_box(bg_in.hcount, bg_in.vcount, 160, 180, 0, 200) ||
                      in_box(bg_in.hcount, bg_in.vcount, 160, 280, 180, 200) ||
                      in_box(bg_in.hcount, bg_in.vcount, 280, 300, 0, 200) ||
                      in_box(bg_in.hcount, bg_in.vcount, 220, 240, 80, 200);

    // squared distance from the circle centre
    assign dx        = signed'({2'b00, bg_in.hcount}) - 13'(`CIRCLE_X);
    assign dy        = signed'({2'b00, bg_in.vcount}) - 13'(`CIRCLE_Y);
    assign dist2     = dx * dx + dy * dy;
    assign in_circle = (dist2 < 26'(`CIRCLE_R2));

    // priority order, first match wins
    always_comb begin
        if (bg_in.vblnk || bg_in.hblnk) begin
            rgb_nxt = '0;                                   // black in blanking
        end else if (bg_in.vcount == 11'd0) begin
            rgb_nxt = `COLOR_TOP;
        end else if (bg_in.vcount == count_t'(`VER_PIXELS - 1)) begin
            rgb_nxt = `COLOR_BOTTOM;
        end else if (bg_in.hcount == 11'd0) begin
            rgb_nxt = `COLOR_LEFT;
        end else if (bg_in.hcount == count_t'(`HOR_PIXELS - 1)) begin
            rgb_nxt = `COLOR_RIGHT;
        end else if (letter_1 || letter_2) begin
            rgb_nxt = `COLOR_LETTER;
        end else if (in_circle) begin
            rgb_nxt = `COLOR_CIRCLE;                        // letters sit on top
        end else begin
            rgb_nxt = `COLOR_FILL;
        end
    end

    always_comb begin
        bg_nxt     = bg_in;                                 // timing passes unchanged
        bg_nxt.rgb = rgb_nxt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bg_out <= '0;
        end else begin
            bg_out <= bg_nxt;
        end
    end

endmodule

`default_nettype wire

//--- draw_rect.sv
`timescale 1ns/10ps
`default_nettype none

`include "vga_macros.svh"

module draw_rect (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::pos_t     rect_pos,
    input  vga_pkg::vga_sig_t rect_in,
    output vga_pkg::vga_sig_t rect_out
);

    import vga_pkg::*;

    pos_t        pos_q;
    pos_t        pos_cur;
    logic        frame_start;
    logic        in_rect;
    logic [11:0] x_end;
    logic [11:0] y_end;
    vga_sig_t    rect_nxt;

    assign frame_start = (rect_in.hcount == 11'd0) && (rect_in.vcount == 11'd0);

    // first pixel of a frame already uses the fresh sample
    assign pos_cur = frame_start ? rect_pos : pos_q;

    // one extra bit so a far-right position cannot wrap
    assign x_end = {1'b0, pos_cur.x} + 12'(`RECT_WIDTH);
    assign y_end = {1'b0, pos_cur.y} + 12'(`RECT_HEIGHT);

    assign in_rect = !rect_in.hblnk && !rect_in.vblnk &&
                     (rect_in.hcount >= pos_cur.x) && ({1'b0, rect_in.hcount} < x_end) &&
                     (rect_in.vcount >= pos_cur.y) && ({1'b0, rect_in.vcount} < y_end);

    always_comb begin
        rect_nxt = rect_in;
        if (in_rect) begin
            rect_nxt.rgb = `COLOR_RECT;                     // covers the background
        end
    end

    // position held for the whole frame, no tearing
    always_ff @(posedge clk) begin
        if (rst) begin
            pos_q <= '0;
        end else if (frame_start) begin
            pos_q <= rect_pos;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rect_out <= '0;
        end else begin
            rect_out <= rect_nxt;
        end
    end

endmodule

`default_nettype wire

//--- vga_top.sv
`timescale 1ns/10ps
`default_nettype none

module vga_top (
    input  logic          clk,
    input  logic          rst,
    input  vga_pkg::pos_t rect_pos,
    output logic          vs,
    output logic          hs,
    output logic [3:0]    r,
    output logic [3:0]    g,
    output logic [3:0]    b
);

    import vga_pkg::*;

    vga_sig_t tim_sig;
    vga_sig_t bg_sig;
    vga_sig_t rect_sig;

    vga_timing u_vga_timing (
        .clk     (clk),
        .rst     (rst),
        .tim_sig (tim_sig)
    );

    draw_bg u_draw_bg (
        .clk    (clk),
        .rst    (rst),
        .bg_in  (tim_sig),
        .bg_out (bg_sig)
    );

    draw_rect u_draw_rect (
        .clk      (clk),
        .rst      (rst),
        .rect_pos (rect_pos),
        .rect_in  (bg_sig),
        .rect_out (rect_sig)
    );

    // pins straight from the last stage, two cycles after the counters
    assign vs = rect_sig.vsync;
    assign hs = rect_sig.hsync;
    assign r  = rect_sig.rgb[11:8];
    assign g  = rect_sig.rgb[7:4];
    assign b  = rect_sig.rgb[3:0];

endmodule

`default_nettype wire

//--- tb_vga_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "vga_macros.svh"

module tb_vga_top;

    import vga_pkg::*;

    localparam int RUN_CYCLES     = 3 * `HOR_TOTAL * `VER_TOTAL;  // three full frames
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 1000;

    logic       clk;
    logic       rst;
    pos_t       rect_pos;
    logic       vs;
    logic       hs;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    bit [31:0]  rnd_state;
    bit         seen [0:4095];                              // expected colours met so far

    vga_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .rect_pos (rect_pos),
        .vs       (vs),
        .hs       (hs),
        .r        (r),
        .g        (g),
        .b        (b)
    );

    function automatic bit [31:0] xorshift32(input bit [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic bit in_span(input int a, input int lo, input int hi);
        return (a >= lo) && (a <= hi);
    endfunction

    // x, y relative to the letter origin, all strokes inclusive
    function automatic bit on_letter(input int x, input int y);
        bit first;
        bit second;
        first  = (in_span(x, 0, `STROKE) && in_span(y, 0, 200)) ||
                 (in_span(x, 0, 120) && in_span(y, 0, `STROKE)) ||
                 (in_span(x, 120, 140) && in_span(y, 0, 200)) ||
                 (in_span(x, 60, 80) && in_span(y, 0, 120));
        second = (in_span(x, 160, 180) && in_span(y, 0, 200)) ||
                 (in_span(x, 160, 280) && in_span(y, 180, 200)) ||
                 (in_span(x, 280, 300) && in_span(y, 0, 200)) ||
                 (in_span(x, 220, 240) && in_span(y, 80, 200));
        return first || second;
    endfunction

    function automatic rgb_t ref_rgb(input int h, input int v, input pos_t p);
        int px;
        int py;
        int dx;
        int dy;
        px = int'(p.x);
        py = int'(p.y);
        dx = h - `CIRCLE_X;
        dy = v - `CIRCLE_Y;
        if (h >= `HOR_PIXELS || v >= `VER_PIXELS) return 12'h000;
        if (h >= px && h < px + `RECT_WIDTH && v >= py && v < py + `RECT_HEIGHT)
            return `COLOR_RECT;                             // block sits on top
        if (v == 0) return `COLOR_TOP;
        if (v == `VER_PIXELS - 1) return `COLOR_BOTTOM;
        if (h == 0) return `COLOR_LEFT;
        if (h == `HOR_PIXELS - 1) return `COLOR_RIGHT;
        if (on_letter(h - `LETTER_X0, v - `LETTER_Y0)) return `COLOR_LETTER;
        if (dx * dx + dy * dy < `CIRCLE_R2) return `COLOR_CIRCLE;
        return `COLOR_FILL;
    endfunction

    // {hs, vs}, both active high
    function automatic logic [1:0] ref_sync(input int h, input int v);
        logic hs_e;
        logic vs_e;
        hs_e = (h >= `HOR_SYNC_START) && (h <= `HOR_SYNC_END);
        vs_e = (v >= `VER_SYNC_START) && (v <= `VER_SYNC_END);
        return {hs_e, vs_e};
    endfunction

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s colour %03h, expected %03h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "colour mismatch");
        end
    endtask

    task automatic check_sync(input logic hs_got, input logic vs_got,
                              input logic [1:0] exp, input string what);
        if ({hs_got, vs_got} !== exp) begin
            $display("CHECK FAILED at %0t: %s hs/vs %b%b, expected %b", $time, what,
                     hs_got, vs_got, exp);
            $display(">>> FAIL");
            $fatal(1, "sync mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                             // 25 MHz sim clock, 40 ns
    end

    initial begin : stimulus
        int unsigned delay;
        pos_t        new_pos;
        rnd_state  = 32'd44;
        rst        = 1'b1;
        rect_pos.x = 11'd600;                               // clear of the reset bundle at 0,0
        rect_pos.y = 11'd420;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        forever begin
            rnd_state = xorshift32(rnd_state);
            delay     = 100000 + rnd_state % 400000;        // lands anywhere in a frame
            repeat (delay) @(posedge clk);
            rnd_state = xorshift32(rnd_state);
            new_pos.x = count_t'(rnd_state % (`HOR_PIXELS - `RECT_WIDTH + 1));
            rnd_state = xorshift32(rnd_state);
            new_pos.y = count_t'(rnd_state % (`VER_PIXELS - `RECT_HEIGHT + 1));
            rect_pos <= new_pos;
        end
    end

    initial begin : compare
        int    h;
        int    v;
        int    pix;
        pos_t  cur_pos;
        pos_t  next_pos;
        rgb_t  exp_rgb;
        string where;
        @(posedge clk);                                     // registers leave X here
        @(negedge clk);
        while (rst) begin
            check_sync(hs, vs, 2'b00, "in reset");
            check_rgb({r, g, b}, 12'h000, "in reset");
            @(negedge clk);
        end
        check_sync(hs, vs, 2'b00, "first cycle after reset");
        check_rgb({r, g, b}, 12'h000, "first cycle after reset");
        @(negedge clk);
        check_sync(hs, vs, 2'b00, "second cycle after reset");
        check_rgb({r, g, b}, 12'h000, "second cycle after reset");
        next_pos = rect_pos;                                // rect stage sees pixel 0,0 now
        cur_pos  = next_pos;
        h = 0;
        v = 0;
        for (pix = 0; pix < RUN_CYCLES; pix++) begin
            @(negedge clk);
            if (h == 0 && v == 0) cur_pos = next_pos;
            exp_rgb       = ref_rgb(h, v, cur_pos);
            seen[exp_rgb] = 1'b1;
            where         = $sformatf("pixel (%0d,%0d)", h, v);
            check_sync(hs, vs, ref_sync(h, v), where);
            check_rgb({r, g, b}, exp_rgb, where);
            if (h == `HOR_TOTAL - 1 && v == `VER_TOTAL - 1) next_pos = rect_pos;
            if (h == `HOR_TOTAL - 1) begin
                h = 0;
                v = (v == `VER_TOTAL - 1) ? 0 : v + 1;
            end else begin
                h = h + 1;
            end
        end
        if (!(seen[12'h000] && seen[`COLOR_TOP] && seen[`COLOR_BOTTOM] &&
              seen[`COLOR_LEFT] && seen[`COLOR_RIGHT] && seen[`COLOR_LETTER] &&
              seen[`COLOR_CIRCLE] && seen[`COLOR_FILL] && seen[`COLOR_RECT])) begin
            $display("not every background and rectangle colour was exercised");
            $display(">>> FAIL");
            $fatal(1, "colour coverage incomplete");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
vga_pkg.sv
vga_timing.sv
draw_bg.sv
draw_rect.sv
vga_top.sv
tb_vga_top.sv
